// ==== test/ooo_core_tests.txt ====
# name op rd rs1 rs2 use_imm imm expected, all hex but name
# op: 0 add, 1 sub, 2 and, 3 or, 4 xor, 5 sll, 6 srl, 7 slt
addi_r1    0 1 0 0 1 123 00000123
addi_neg   0 2 0 0 1 ff0 fffffff0
add_rr     0 3 1 2 0 000 00000113
sub_rr     1 4 1 2 0 000 00000133
subi       1 5 1 0 1 023 00000100
and_rr     2 6 1 2 0 000 00000120
andi       2 7 2 0 1 0f5 000000f0
or_rr      3 8 6 7 0 000 000001f0
ori_neg    3 9 0 0 1 800 fffff800
xor_rr     4 a 9 2 0 000 000007f0
xori_neg   4 b 1 0 1 fff fffffedc
sll_rr     5 c 1 7 0 000 01230000
slli_mask  5 d 1 0 1 024 00001230
srl_rr     6 e 9 7 0 000 0000ffff
srli       6 f 2 0 1 004 0fffffff
slt_rr     7 3 2 1 0 000 00000001
slti_neg   7 4 1 0 1 fff 00000000
chain_a    0 5 5 0 1 001 00000101
chain_b    0 5 5 5 0 000 00000202
chain_c    5 5 5 0 1 003 00001010
chain_d    1 6 5 1 0 000 00000eed
r0_write   0 0 1 0 1 005 00000128
r0_read    0 7 0 0 0 000 00000000
waw_old    0 8 0 0 1 111 00000111
waw_new    0 8 0 0 1 222 00000222
waw_read   0 9 8 0 1 001 00000223
burst_0    0 a a 0 1 001 000007f1
burst_1    0 a a 0 1 001 000007f2
burst_2    4 b a b 0 000 fffff92e
burst_3    0 a a a 0 000 00000fe4
burst_4    1 c a b 0 000 000016b6
burst_5    3 d c a 0 000 00001ff6
burst_6    7 e b d 0 000 00000001
burst_7    6 f d e 0 000 00000ffb
burst_8    0 1 f c 0 000 000026b1
burst_9    2 2 1 0 1 0ff 000000b1
final_add  0 3 2 8 0 000 000002d3

// ==== ooo_core.f ====
design/isa_pkg.sv
design/core_pkg.sv
design/dispatch_unit.sv
design/reservation_station.sv
design/alu_stage.sv
design/reorder_buffer.sv
design/ooo_core.sv
test/ooo_core_checker.sv
test/ooo_core_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module ooo_core_tb \
    -f ooo_core.f -o ooo_core_sim \
    && ./obj_dir/ooo_core_sim > sim.log 2>&1 \
    || echo "build or simulation did not complete" >> sim.log
cat sim.log
grep -q "TESTS FAILED" sim.log && exit 1
grep -q "TESTS PASSED" sim.log || exit 1
exit 0

// ==== test/ooo_core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module ooo_core_tb;

    logic              clock;
    logic              reset;
    logic              in_valid;
    logic              in_ready;
    isa_pkg::alu_op_t  in_op;
    isa_pkg::reg_idx_t in_rd;
    isa_pkg::reg_idx_t in_rs1;
    isa_pkg::reg_idx_t in_rs2;
    logic              in_use_imm;
    isa_pkg::imm_t     in_imm;
    logic              commit_valid;
    isa_pkg::reg_idx_t commit_rd;
    isa_pkg::data_t    commit_value;

    // one entry per test line
    string             test_name    [$];
    isa_pkg::alu_op_t  test_op      [$];
    isa_pkg::reg_idx_t test_rd      [$];
    isa_pkg::reg_idx_t test_rs1     [$];
    isa_pkg::reg_idx_t test_rs2     [$];
    logic              test_use_imm [$];
    isa_pkg::imm_t     test_imm     [$];
    isa_pkg::data_t    test_value   [$];

    int unsigned cycle_count;
    int unsigned cycle_limit;
    int          bench_errors;
    logic        saw_stall;

    ooo_core UUT (
        .clock, .reset,
        .in_valid, .in_ready, .in_op, .in_rd, .in_rs1, .in_rs2, .in_use_imm, .in_imm,
        .commit_valid, .commit_rd, .commit_value
    );

    ooo_core_checker check (
        .clock, .reset,
        .commit_valid, .commit_rd, .commit_value
    );

    // 8 ns clock
    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    always @(posedge clock) begin
        if (reset) begin
            cycle_count <= 0;
        end else begin
            cycle_count <= cycle_count + 1;
        end
    end

    //////////////////////////////
    // test file reader
    //////////////////////////////

    task automatic read_tests();
        int          fd;
        int          code;
        int          c;
        string       name;
        logic [31:0] op;
        logic [31:0] rd;
        logic [31:0] rs1;
        logic [31:0] rs2;
        logic [31:0] use_imm;
        logic [31:0] imm;
        logic [31:0] expected;
        fd = $fopen("test/ooo_core_tests.txt", "r");
        if (fd == 0) begin
            $display("cannot open test/ooo_core_tests.txt");
            bench_errors++;
            return;
        end
        code = $fscanf(fd, "%s", name);
        while (code == 1) begin
            // '#' starts a comment line
            if (name.getc(0) == 8'h23) begin
                c = $fgetc(fd);
                while (c != 10 && c != -1) begin
                    c = $fgetc(fd);
                end
            end else begin
                code = $fscanf(fd, "%h %h %h %h %h %h %h",
                               op, rd, rs1, rs2, use_imm, imm, expected);
                if (code != 7) begin
                    $display("test %s has a malformed line in the test file", name);
                    bench_errors++;
                    break;
                end
                test_name.push_back(name);
                test_op.push_back(isa_pkg::alu_op_t'(op[2:0]));
                test_rd.push_back(rd[3:0]);
                test_rs1.push_back(rs1[3:0]);
                test_rs2.push_back(rs2[3:0]);
                test_use_imm.push_back(use_imm[0]);
                test_imm.push_back(imm[11:0]);
                test_value.push_back(expected);
            end
            code = $fscanf(fd, "%s", name);
        end
        $fclose(fd);
    endtask

    //////////////////////////////
    // stimulus
    //////////////////////////////

    // lines of the back-to-back burst
    function automatic bit is_burst(input string name);
        return name.substr(0, 4) == "burst";
    endfunction

    // entered and left 1 ns after a rising edge
    task automatic send(input int idx);
        in_valid   = 1'b1;
        in_op      = test_op[idx];
        in_rd      = test_rd[idx];
        in_rs1     = test_rs1[idx];
        in_rs2     = test_rs2[idx];
        in_use_imm = test_use_imm[idx];
        in_imm     = test_imm[idx];
        // in_ready only depends on registered state
        while (!in_ready) begin
            if (is_burst(test_name[idx])) begin
                saw_stall = 1'b1;
            end
            @(posedge clock);
            #1;
        end
        @(posedge clock);
        check.expect_commit(test_name[idx], test_rd[idx], test_value[idx]);
        #1;
        in_valid = 1'b0;
    endtask

    task automatic print_counts();
        $display("errors: %0d wrong commits, %0d other failures",
                 check.value_errors, check.other_errors + bench_errors);
    endtask

    initial begin
        int gap;
        void'($urandom(32'h9ec2_5ed5));
        reset        = 1'b1;
        in_valid     = 1'b0;
        in_op        = isa_pkg::op_add;
        in_rd        = '0;
        in_rs1       = '0;
        in_rs2       = '0;
        in_use_imm   = 1'b0;
        in_imm       = '0;
        cycle_limit  = 0;
        bench_errors = 0;
        saw_stall    = 1'b0;
        read_tests();
        if (test_name.size() == 0) begin
            $display("no tests were read from the test file");
            bench_errors++;
        end
        cycle_limit = 40 * test_name.size() + 100;
        repeat (8) @(posedge clock);
        #1;
        reset = 1'b0;
        if (!in_ready) begin
            $display("in_ready is low after reset");
            bench_errors++;
        end
        for (int i = 0; i < test_name.size(); i++) begin
            // burst lines go back to back
            if (!is_burst(test_name[i])) begin
                gap = $urandom % 4;
                repeat (gap) begin
                    @(posedge clock);
                    #1;
                end
            end
            send(i);
        end
        while (check.pending() != 0) begin
            @(posedge clock);
        end
        // room for a stray extra commit
        repeat (6) @(posedge clock);
        if (!saw_stall) begin
            $display("in_ready never dropped during the burst");
            bench_errors++;
        end
        print_counts();
        if (check.value_errors == 0 && check.other_errors == 0 && bench_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        wait (cycle_limit != 0);
        wait (cycle_count >= cycle_limit);
        $display("timeout after %0d cycles, %0d commits still missing",
                 cycle_count, check.pending());
        print_counts();
        $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== test/ooo_core_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module ooo_core_checker (
    input  logic              clock,
    input  logic              reset,
    input  logic              commit_valid,
    input  isa_pkg::reg_idx_t commit_rd,
    input  isa_pkg::data_t    commit_value
);

    // expected commits in program order
    string             expected_name  [$];
    isa_pkg::reg_idx_t expected_rd    [$];
    isa_pkg::data_t    expected_value [$];

    int value_errors;
    int other_errors;

    initial begin
        value_errors = 0;
        other_errors = 0;
    end

    // pushed by the bench on each transfer edge
    task automatic expect_commit(
        input string             name,
        input isa_pkg::reg_idx_t rd,
        input isa_pkg::data_t    value
    );
        expected_name.push_back(name);
        expected_rd.push_back(rd);
        expected_value.push_back(value);
    endtask

    function automatic int pending();
        return expected_name.size();
    endfunction

    //////////////////////////////
    // commit compare
    //////////////////////////////

    // commit port is registered, stable at the falling edge
    always @(negedge clock) begin
        string             name;
        isa_pkg::reg_idx_t rd;
        isa_pkg::data_t    value;
        if (!reset && commit_valid) begin
            if (expected_name.size() == 0) begin
                $display("commit of rd %0d value %h with no instruction pending",
                         commit_rd, commit_value);
                other_errors++;
            end else begin
                name  = expected_name.pop_front();
                rd    = expected_rd.pop_front();
                value = expected_value.pop_front();
                // rd order shows program order
                if (commit_rd != rd || commit_value != value) begin
                    $display("** Error %s: expected rd %0d value %h, actual rd %0d value %h",
                             name, rd, value, commit_rd, commit_value);
                    value_errors++;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/ooo_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module ooo_core (
    input  logic               clock,
    input  logic               reset,
    input  logic               in_valid,
    output logic               in_ready,
    input  isa_pkg::alu_op_t   in_op,
    input  isa_pkg::reg_idx_t  in_rd,
    input  isa_pkg::reg_idx_t  in_rs1,
    input  isa_pkg::reg_idx_t  in_rs2,
    input  logic               in_use_imm,
    input  isa_pkg::imm_t      in_imm,
    output logic               commit_valid,
    output isa_pkg::reg_idx_t  commit_rd,
    output isa_pkg::data_t     commit_value
);

    // dispatch to reorder buffer
    logic               rob_alloc;
    logic               rob_full;
    isa_pkg::reg_idx_t  rob_alloc_rd;
    core_pkg::rob_tag_t rob_alloc_tag;
    core_pkg::rob_tag_t rob_lookup_tag1;
    core_pkg::rob_tag_t rob_lookup_tag2;
    logic               rob_lookup_done1;
    logic               rob_lookup_done2;
    isa_pkg::data_t     rob_lookup_value1;
    isa_pkg::data_t     rob_lookup_value2;

    // dispatch to station
    logic               rs_load;
    logic               rs_full;
    isa_pkg::alu_op_t   rs_op;
    core_pkg::rob_tag_t rs_tag;
    logic               rs_ready1;
    logic               rs_ready2;
    isa_pkg::data_t     rs_value1;
    isa_pkg::data_t     rs_value2;
    core_pkg::rob_tag_t rs_src_tag1;
    core_pkg::rob_tag_t rs_src_tag2;
    logic               rs_use_imm;
    isa_pkg::imm_t      rs_imm;

    // station to ALU
    logic               issue_valid;
    isa_pkg::alu_op_t   issue_op;
    core_pkg::rob_tag_t issue_tag;
    isa_pkg::data_t     issue_a;
    isa_pkg::data_t     issue_b;
    logic               issue_use_imm;
    isa_pkg::imm_t      issue_imm;

    // result bus, single unit so no arbiter
    logic               cdb_valid;
    core_pkg::rob_tag_t cdb_tag;
    isa_pkg::data_t     cdb_value;

    core_pkg::rob_tag_t commit_tag;

    dispatch_unit dispatch (
        .clock, .reset,
        .in_valid, .in_ready, .in_op, .in_rd, .in_rs1, .in_rs2, .in_use_imm, .in_imm,
        .rob_full, .rob_alloc_tag, .rob_alloc, .rob_alloc_rd,
        .rob_lookup_tag1, .rob_lookup_tag2, .rob_lookup_done1, .rob_lookup_done2,
        .rob_lookup_value1, .rob_lookup_value2,
        .rs_full, .rs_load, .rs_op, .rs_tag, .rs_ready1, .rs_ready2,
        .rs_value1, .rs_value2, .rs_src_tag1, .rs_src_tag2, .rs_use_imm, .rs_imm,
        .cdb_valid, .cdb_tag, .cdb_value,
        .commit_valid, .commit_rd, .commit_tag, .commit_value
    );

    reservation_station station (
        .clock, .reset,
        .rs_load, .rs_op, .rs_tag, .rs_ready1, .rs_ready2, .rs_value1, .rs_value2,
        .rs_src_tag1, .rs_src_tag2, .rs_use_imm, .rs_imm, .rs_full,
        .cdb_valid, .cdb_tag, .cdb_value,
        .issue_valid, .issue_op, .issue_tag, .issue_a, .issue_b,
        .issue_use_imm, .issue_imm
    );

    alu_stage alu (
        .clock, .reset,
        .issue_valid, .issue_op, .issue_tag, .issue_a, .issue_b,
        .issue_use_imm, .issue_imm,
        .cdb_valid, .cdb_tag, .cdb_value
    );

    reorder_buffer rob (
        .clock, .reset,
        .rob_alloc, .rob_alloc_rd, .rob_alloc_tag, .rob_full,
        .cdb_valid, .cdb_tag, .cdb_value,
        .rob_lookup_tag1, .rob_lookup_tag2, .rob_lookup_done1, .rob_lookup_done2,
        .rob_lookup_value1, .rob_lookup_value2,
        .commit_valid, .commit_rd, .commit_tag, .commit_value
    );

endmodule

`default_nettype wire

// ==== design/reorder_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module reorder_buffer (
    input  logic                clock,
    input  logic                reset,
    // allocation
    input  logic                rob_alloc,
    input  isa_pkg::reg_idx_t   rob_alloc_rd,
    output core_pkg::rob_tag_t  rob_alloc_tag,
    output logic                rob_full,
    // result bus
    input  logic                cdb_valid,
    input  core_pkg::rob_tag_t  cdb_tag,
    input  isa_pkg::data_t      cdb_value,
    // operand lookup for dispatch
    input  core_pkg::rob_tag_t  rob_lookup_tag1,
    input  core_pkg::rob_tag_t  rob_lookup_tag2,
    output logic                rob_lookup_done1,
    output logic                rob_lookup_done2,
    output isa_pkg::data_t      rob_lookup_value1,
    output isa_pkg::data_t      rob_lookup_value2,
    // retirement
    output logic                commit_valid,
    output isa_pkg::reg_idx_t   commit_rd,
    output core_pkg::rob_tag_t  commit_tag,
    output isa_pkg::data_t      commit_value
);

    core_pkg::rob_state_t state [core_pkg::rob_size];
    isa_pkg::reg_idx_t    dest  [core_pkg::rob_size];
    isa_pkg::data_t       value [core_pkg::rob_size];

    core_pkg::rob_tag_t              head;
    core_pkg::rob_tag_t              tail;
    logic [$clog2(core_pkg::rob_size):0] count;
    logic                            retire;

    // head leaves once its result is in
    assign retire = state[head] == core_pkg::rob_done;

    assign rob_alloc_tag = tail;
    assign rob_full      = count == $bits(count)'(core_pkg::rob_size);

    // lookup ports
    assign rob_lookup_done1  = state[rob_lookup_tag1] == core_pkg::rob_done;
    assign rob_lookup_done2  = state[rob_lookup_tag2] == core_pkg::rob_done;
    assign rob_lookup_value1 = value[rob_lookup_tag1];
    assign rob_lookup_value2 = value[rob_lookup_tag2];

    //////////////////////////////
    // entry state and pointers
    //////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < core_pkg::rob_size; i++) begin
                state[i] <= core_pkg::rob_empty;
            end
            head         <= '0;
            tail         <= '0;
            count        <= '0;
            commit_valid <= 1'b0;
        end else begin
            if (cdb_valid) begin
                state[cdb_tag] <= core_pkg::rob_done;
            end
            if (retire) begin
                state[head] <= core_pkg::rob_empty;
                head        <= head + 1'b1;
            end
            // tail never meets a retiring head, the buffer would be full
            if (rob_alloc) begin
                state[tail] <= core_pkg::rob_busy;
                tail        <= tail + 1'b1;
            end
            case ({rob_alloc, retire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            commit_valid <= retire;
        end
    end

    //////////////////////////////
    // payload and commit port
    //////////////////////////////

    always_ff @(posedge clock) begin
        if (rob_alloc) begin
            dest[tail] <= rob_alloc_rd;
        end
        if (cdb_valid) begin
            value[cdb_tag] <= cdb_value;
        end
        // registered, qualified by commit_valid
        commit_rd    <= dest[head];
        commit_tag   <= head;
        commit_value <= value[head];
    end

    // the ALU only answers instructions that were dispatched
    assert property (@(posedge clock) disable iff (reset)
        cdb_valid |-> state[cdb_tag] != core_pkg::rob_empty);

endmodule

`default_nettype wire

// ==== design/alu_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_stage (
    input  logic                clock,
    input  logic                reset,
    input  logic                issue_valid,
    input  isa_pkg::alu_op_t    issue_op,
    input  core_pkg::rob_tag_t  issue_tag,
    input  isa_pkg::data_t      issue_a,
    input  isa_pkg::data_t      issue_b,
    input  logic                issue_use_imm,
    input  isa_pkg::imm_t       issue_imm,
    // result bus
    output logic                cdb_valid,
    output core_pkg::rob_tag_t  cdb_tag,
    output isa_pkg::data_t      cdb_value
);

    isa_pkg::data_t operand_b;
    isa_pkg::data_t result;

    // sign-extended immediate or register operand
    assign operand_b = issue_use_imm ? isa_pkg::data_t'($signed(issue_imm)) : issue_b;

    always_comb begin
        case (issue_op)
            isa_pkg::op_add: result = issue_a + operand_b;
            isa_pkg::op_sub: result = issue_a - operand_b;
            isa_pkg::op_and: result = issue_a & operand_b;
            isa_pkg::op_or:  result = issue_a | operand_b;
            isa_pkg::op_xor: result = issue_a ^ operand_b;
            // shift amount from the low 5 bits
            isa_pkg::op_sll: result = issue_a << operand_b[4:0];
            isa_pkg::op_srl: result = issue_a >> operand_b[4:0];
            isa_pkg::op_slt: result = isa_pkg::data_t'($signed(issue_a) < $signed(operand_b));
            default:         result = '0;
        endcase
    end

    // broadcast one cycle after issue
    always_ff @(posedge clock) begin
        if (reset) begin
            cdb_valid <= 1'b0;
        end else begin
            cdb_valid <= issue_valid;
        end
    end

    always_ff @(posedge clock) begin
        cdb_tag   <= issue_tag;
        cdb_value <= result;
    end

endmodule

`default_nettype wire

// ==== design/reservation_station.sv ====
`timescale 1ns/1ps
`default_nettype none

module reservation_station (
    input  logic                clock,
    input  logic                reset,
    // load from dispatch
    input  logic                rs_load,
    input  isa_pkg::alu_op_t    rs_op,
    input  core_pkg::rob_tag_t  rs_tag,
    input  logic                rs_ready1,
    input  logic                rs_ready2,
    input  isa_pkg::data_t      rs_value1,
    input  isa_pkg::data_t      rs_value2,
    input  core_pkg::rob_tag_t  rs_src_tag1,
    input  core_pkg::rob_tag_t  rs_src_tag2,
    input  logic                rs_use_imm,
    input  isa_pkg::imm_t       rs_imm,
    output logic                rs_full,
    // result bus
    input  logic                cdb_valid,
    input  core_pkg::rob_tag_t  cdb_tag,
    input  isa_pkg::data_t      cdb_value,
    // issue to the ALU
    output logic                issue_valid,
    output isa_pkg::alu_op_t    issue_op,
    output core_pkg::rob_tag_t  issue_tag,
    output isa_pkg::data_t      issue_a,
    output isa_pkg::data_t      issue_b,
    output logic                issue_use_imm,
    output isa_pkg::imm_t       issue_imm
);

    logic [core_pkg::rs_size-1:0] valid;

    // entry payload
    isa_pkg::alu_op_t   op       [core_pkg::rs_size];
    core_pkg::rob_tag_t tag      [core_pkg::rs_size];
    logic               ready1   [core_pkg::rs_size];
    logic               ready2   [core_pkg::rs_size];
    isa_pkg::data_t     value1   [core_pkg::rs_size];
    isa_pkg::data_t     value2   [core_pkg::rs_size];
    core_pkg::rob_tag_t src_tag1 [core_pkg::rs_size];
    core_pkg::rob_tag_t src_tag2 [core_pkg::rs_size];
    logic               use_imm  [core_pkg::rs_size];
    isa_pkg::imm_t      imm      [core_pkg::rs_size];
    // number of older valid entries, 0 is the oldest
    core_pkg::rs_idx_t  age      [core_pkg::rs_size];

    logic              pick_found;
    core_pkg::rs_idx_t pick;
    core_pkg::rs_idx_t free_slot;
    core_pkg::rs_idx_t new_age;

    assign rs_full = &valid;

    //////////////////////////////
    // oldest-ready select
    //////////////////////////////

    always_comb begin
        pick_found = 1'b0;
        pick       = '0;
        free_slot  = '0;
        new_age    = '0;
        for (int i = 0; i < core_pkg::rs_size; i++) begin
            if (valid[i] && ready1[i] && ready2[i] && (!pick_found || age[i] < age[pick])) begin
                pick_found = 1'b1;
                pick       = core_pkg::rs_idx_t'(i);
            end
        end
        // lowest free slot
        for (int i = core_pkg::rs_size - 1; i >= 0; i--) begin
            if (!valid[i]) begin
                free_slot = core_pkg::rs_idx_t'(i);
            end
        end
        // a loaded entry is younger than all that stay
        for (int i = 0; i < core_pkg::rs_size; i++) begin
            if (valid[i] && !(pick_found && pick == core_pkg::rs_idx_t'(i))) begin
                new_age = new_age + 1'b1;
            end
        end
    end

    assign issue_valid   = pick_found;
    assign issue_op      = op[pick];
    assign issue_tag     = tag[pick];
    assign issue_a       = value1[pick];
    assign issue_b       = value2[pick];
    assign issue_use_imm = use_imm[pick];
    assign issue_imm     = imm[pick];

    //////////////////////////////
    // wakeup, free and load
    //////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            valid <= '0;
        end else begin
            for (int i = 0; i < core_pkg::rs_size; i++) begin
                // capture a matching broadcast
                if (valid[i] && cdb_valid && !ready1[i] && src_tag1[i] == cdb_tag) begin
                    ready1[i] <= 1'b1;
                    value1[i] <= cdb_value;
                end
                if (valid[i] && cdb_valid && !ready2[i] && src_tag2[i] == cdb_tag) begin
                    ready2[i] <= 1'b1;
                    value2[i] <= cdb_value;
                end
                // younger entries move up past the issued one
                if (pick_found && valid[i] && age[i] > age[pick]) begin
                    age[i] <= age[i] - 1'b1;
                end
            end
            if (pick_found) begin
                valid[pick] <= 1'b0;
            end
            if (rs_load) begin
                valid[free_slot]    <= 1'b1;
                op[free_slot]       <= rs_op;
                tag[free_slot]      <= rs_tag;
                ready1[free_slot]   <= rs_ready1;
                ready2[free_slot]   <= rs_ready2;
                value1[free_slot]   <= rs_value1;
                value2[free_slot]   <= rs_value2;
                src_tag1[free_slot] <= rs_src_tag1;
                src_tag2[free_slot] <= rs_src_tag2;
                use_imm[free_slot]  <= rs_use_imm;
                imm[free_slot]      <= rs_imm;
                age[free_slot]      <= new_age;
            end
        end
    end

    // dispatch holds off while every entry is taken
    assert property (@(posedge clock) disable iff (reset) rs_load |-> !rs_full);

endmodule

`default_nettype wire

// ==== design/dispatch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module dispatch_unit (
    input  logic                clock,
    input  logic                reset,
    // decoded instruction
    input  logic                in_valid,
    output logic                in_ready,
    input  isa_pkg::alu_op_t    in_op,
    input  isa_pkg::reg_idx_t   in_rd,
    input  isa_pkg::reg_idx_t   in_rs1,
    input  isa_pkg::reg_idx_t   in_rs2,
    input  logic                in_use_imm,
    input  isa_pkg::imm_t       in_imm,
    // reorder buffer
    input  logic                rob_full,
    input  core_pkg::rob_tag_t  rob_alloc_tag,
    output logic                rob_alloc,
    output isa_pkg::reg_idx_t   rob_alloc_rd,
    output core_pkg::rob_tag_t  rob_lookup_tag1,
    output core_pkg::rob_tag_t  rob_lookup_tag2,
    input  logic                rob_lookup_done1,
    input  logic                rob_lookup_done2,
    input  isa_pkg::data_t      rob_lookup_value1,
    input  isa_pkg::data_t      rob_lookup_value2,
    // reservation station
    input  logic                rs_full,
    output logic                rs_load,
    output isa_pkg::alu_op_t    rs_op,
    output core_pkg::rob_tag_t  rs_tag,
    output logic                rs_ready1,
    output logic                rs_ready2,
    output isa_pkg::data_t      rs_value1,
    output isa_pkg::data_t      rs_value2,
    output core_pkg::rob_tag_t  rs_src_tag1,
    output core_pkg::rob_tag_t  rs_src_tag2,
    output logic                rs_use_imm,
    output isa_pkg::imm_t       rs_imm,
    // result bus
    input  logic                cdb_valid,
    input  core_pkg::rob_tag_t  cdb_tag,
    input  isa_pkg::data_t      cdb_value,
    // retirement
    input  logic                commit_valid,
    input  isa_pkg::reg_idx_t   commit_rd,
    input  core_pkg::rob_tag_t  commit_tag,
    input  isa_pkg::data_t      commit_value
);

    // architectural registers plus rename state
    isa_pkg::data_t     reg_value  [isa_pkg::reg_count];
    logic               reg_busy   [isa_pkg::reg_count];
    core_pkg::rob_tag_t rename_tag [isa_pkg::reg_count];

    logic           fire;
    logic           src_ready1;
    logic           src_ready2;
    logic           tag_live;

    // one source operand
    // file value, else the retiring result, else the done ROB entry,
    // else this cycle's result bus, else wait on the tag
    function automatic void resolve(
        input  logic               busy,
        input  core_pkg::rob_tag_t tag,
        input  isa_pkg::data_t     file_value,
        input  logic               done,
        input  isa_pkg::data_t     done_value,
        output logic               ready,
        output isa_pkg::data_t     value
    );
        ready = 1'b1;
        value = file_value;
        if (busy) begin
            if (commit_valid && commit_tag == tag) begin
                value = commit_value;
            end else if (done) begin
                value = done_value;
            end else if (cdb_valid && cdb_tag == tag) begin
                value = cdb_value;
            end else begin
                ready = 1'b0;
            end
        end
    endfunction

    //////////////////////////////
    // handshake and allocation
    //////////////////////////////

    assign in_ready = !rob_full && !rs_full;
    assign fire     = in_valid && in_ready;

    assign rob_alloc    = fire;
    assign rob_alloc_rd = in_rd;

    // ask the ROB about the current producers
    assign rob_lookup_tag1 = rename_tag[in_rs1];
    assign rob_lookup_tag2 = rename_tag[in_rs2];

    always_comb begin
        resolve(reg_busy[in_rs1], rename_tag[in_rs1], reg_value[in_rs1],
                rob_lookup_done1, rob_lookup_value1, src_ready1, rs_value1);
        resolve(reg_busy[in_rs2], rename_tag[in_rs2], reg_value[in_rs2],
                rob_lookup_done2, rob_lookup_value2, src_ready2, rs_value2);
    end

    // station entry
    assign rs_load     = fire;
    assign rs_op       = in_op;
    assign rs_tag      = rob_alloc_tag;
    assign rs_ready1   = src_ready1;
    // operand b is not needed with an immediate
    assign rs_ready2   = src_ready2 || in_use_imm;
    assign rs_src_tag1 = rename_tag[in_rs1];
    assign rs_src_tag2 = rename_tag[in_rs2];
    assign rs_use_imm  = in_use_imm;
    assign rs_imm      = in_imm;

    //////////////////////////////
    // register file and renaming
    //////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < isa_pkg::reg_count; i++) begin
                reg_value[i]  <= '0;
                reg_busy[i]   <= 1'b0;
                rename_tag[i] <= '0;
            end
        end else begin
            // retirement leaves r0 at zero
            if (commit_valid && commit_rd != '0) begin
                reg_value[commit_rd] <= commit_value;
                // a younger writer keeps the register renamed
                if (rename_tag[commit_rd] == commit_tag) begin
                    reg_busy[commit_rd] <= 1'b0;
                end
            end
            // new producer wins over a same-cycle retirement
            if (fire && in_rd != '0) begin
                reg_busy[in_rd]   <= 1'b1;
                rename_tag[in_rd] <= rob_alloc_tag;
            end
        end
    end

    // tail tag still held by a renamed producer
    always_comb begin
        tag_live = 1'b0;
        for (int i = 0; i < isa_pkg::reg_count; i++) begin
            if (reg_busy[i] && rename_tag[i] == rob_alloc_tag) begin
                tag_live = 1'b1;
            end
        end
        // producer already retired, only the file write is left
        if (commit_valid && commit_tag == rob_alloc_tag) begin
            tag_live = 1'b0;
        end
    end

    // dispatch into a full ROB would reuse the tag of a live entry
    assert property (@(posedge clock) disable iff (reset) rob_alloc |-> !tag_live);

endmodule

`default_nettype wire

// ==== design/core_pkg.sv ====
`default_nettype none

package core_pkg;

    // reorder buffer depth, power of two so the pointers wrap
    localparam int rob_size = 8;

    // reservation station depth
    localparam int rs_size = 4;

    typedef logic [$clog2(rob_size)-1:0] rob_tag_t;
    typedef logic [$clog2(rs_size)-1:0]  rs_idx_t;

    // life of one reorder buffer entry
    // empty -> busy at dispatch, busy -> done on the result bus,
    // done -> empty at retirement
    typedef enum logic [1:0] {
        rob_empty = 2'd0,
        rob_busy  = 2'd1,
        rob_done  = 2'd2
    } rob_state_t;

endpackage

`default_nettype wire

// ==== design/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

    // datapath width and architectural register count
    localparam int xlen      = 32;
    localparam int reg_count = 16;

    typedef logic [xlen-1:0]              data_t;
    typedef logic [$clog2(reg_count)-1:0] reg_idx_t;

    // immediate field, sign-extended by the ALU
    typedef logic [11:0] imm_t;

    // ALU operation encodings
    // shifts take the low 5 bits of operand b, slt compares signed
    typedef enum logic [2:0] {
        op_add = 3'd0,
        op_sub = 3'd1,
        op_and = 3'd2,
        op_or  = 3'd3,
        op_xor = 3'd4,
        op_sll = 3'd5,
        op_srl = 3'd6,
        op_slt = 3'd7
    } alu_op_t;

endpackage

`default_nettype wire
